// ==== global_mem.sv ====
`default_nettype none
`include "mvm_defines.svh"

module global_mem
    import mvm_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  load_t                  load,
    input  logic                   load_valid,
    input  logic                   busy,
    input  load_sel_e              rd_sel,
    input  logic [`MVM_ADDR_W-1:0] rd_addr,
    output logic [`MVM_DATA_W-1:0] rd_data
);

    localparam int VEC_AW = $clog2(`MVM_COLS);

    logic [`MVM_DATA_W-1:0] weight_mem [`MVM_ROWS*`MVM_COLS];
    logic [`MVM_DATA_W-1:0] vector_mem [`MVM_COLS];
    logic                   wr_ok;

    // Host writes are locked out while a run reads the arrays
    assign wr_ok = load_valid && !busy;

    always_ff @(posedge clk) begin
        if (wr_ok && load.sel == LOAD_WEIGHT) begin
            weight_mem[load.addr] <= load.data;
        end
        if (wr_ok && load.sel == LOAD_VECTOR) begin
            vector_mem[load.addr[VEC_AW-1:0]] <= load.data;
        end
    end

    // One cycle read latency for both arrays
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_sel == LOAD_WEIGHT) begin
            rd_data <= weight_mem[rd_addr];
        end else begin
            rd_data <= vector_mem[rd_addr[VEC_AW-1:0]];
        end
    end

endmodule

`default_nettype wire

// ==== mac_array.sv ====
`default_nettype none
`include "mvm_defines.svh"

module mac_array
    import mvm_pkg::*;
(
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic [1:0]                                           bank_full,
    output logic                                                 rd_bank,
    input  logic [`MVM_TILE-1:0][`MVM_TILE-1:0][`MVM_DATA_W-1:0] weights,
    input  logic [`MVM_TILE-1:0][`MVM_DATA_W-1:0]                vec,
    input  tile_tag_t                                            tag,
    output logic                                                 bank_release,
    output partial_t                                             part,
    output logic                                                 part_valid
);

    localparam int LANE_W = $clog2(`MVM_TILE);
    localparam int PROD_W = 2 * `MVM_DATA_W;

    mac_state_e                  state;
    logic [LANE_W-1:0]           col;
    logic                        tile_go;
    logic signed [PROD_W-1:0]    prod [`MVM_TILE];
    logic signed [`MVM_ACC_W-1:0] acc [`MVM_TILE];

    // Next tile waits until the previous bank has been handed back
    assign tile_go = (state == MAC_IDLE) && bank_full[rd_bank] && !bank_release;

    // Lane l takes row l of the tile, all lanes share one column per cycle
    always_comb begin
        for (int l = 0; l < `MVM_TILE; l++) begin
            prod[l] = $signed(weights[l][col]) * $signed(vec[col]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= MAC_IDLE;
            col          <= '0;
            rd_bank      <= 1'b0;
            bank_release <= 1'b0;
            part_valid   <= 1'b0;
        end else begin
            bank_release <= 1'b0;
            part_valid   <= 1'b0;
            if (bank_release) begin
                rd_bank <= ~rd_bank;
            end
            case (state)
                MAC_IDLE: begin
                    if (tile_go) begin
                        col   <= '0;
                        state <= MAC_RUN;
                    end
                end
                MAC_RUN: begin
                    col <= col + 1'b1;
                    if (col == LANE_W'(`MVM_TILE - 1)) begin
                        bank_release <= 1'b1;
                        part_valid   <= 1'b1;
                        state        <= MAC_IDLE;
                    end
                end
                default: state <= MAC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < `MVM_TILE; l++) begin
            if (tile_go) begin
                acc[l] <= '0;
            end else if (state == MAC_RUN) begin
                acc[l] <= acc[l] + prod[l];
            end
        end
    end

    // Tag still comes from the released bank, rd_bank flips after part_valid
    always_comb begin
        for (int l = 0; l < `MVM_TILE; l++) begin
            part.sum[l] = acc[l];
        end
        part.tag = tag;
    end

endmodule

`default_nettype wire

// ==== mvm_chk.sv ====
`default_nettype none

module mvm_chk (
    input logic       clk,
    input logic       rst_n,
    input logic       busy,
    input logic       done,
    input logic       part_valid,
    input logic [1:0] bank_full,
    input logic       rd_bank
);

    timeunit 1ns;
    timeprecision 1ps;

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done stayed high for more than one cycle");

    done_in_run: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
        else $error("done seen while busy was low");

    idle_in_reset: assert property (@(posedge clk) !rst_n |-> !busy)
        else $error("busy high during reset");

    // Partial sums only come out of a bank the loader had committed
    part_from_full: assert property (@(posedge clk) disable iff (!rst_n)
                                     part_valid |-> bank_full[rd_bank])
        else $error("part_valid from a bank that was not full");

endmodule

bind mvm_top mvm_chk u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .busy       (busy),
    .done       (done),
    .part_valid (part_valid),
    .bank_full  (bank_full),
    .rd_bank    (rd_bank)
);

`default_nettype wire

// ==== mvm_defines.svh ====
`ifndef MVM_DEFINES_SVH
`define MVM_DEFINES_SVH

// Matrix shape, rows by columns
`define MVM_ROWS 8
`define MVM_COLS 8

// Edge of one square tile
`define MVM_TILE 4

// Weight and vector word width
`define MVM_DATA_W 16

// Accumulator and result width, wide enough for a full row of products
`define MVM_ACC_W 40

// External write address, weights stored as row * MVM_COLS + column
`define MVM_ADDR_W 6

`endif

// ==== mvm_pkg.sv ====
`default_nettype none
`include "mvm_defines.svh"

package mvm_pkg;

    // Target array of an external write or a loader read
    typedef enum logic {
        LOAD_WEIGHT,
        LOAD_VECTOR
    } load_sel_e;

    typedef struct packed {
        load_sel_e              sel;
        logic [`MVM_ADDR_W-1:0] addr;
        logic [`MVM_DATA_W-1:0] data;
    } load_t;

    // Position of a tile inside the matrix
    typedef struct packed {
        logic [$clog2(`MVM_ROWS/`MVM_TILE)-1:0] row_tile;
        logic                                   first_col;
        logic                                   last_col;
    } tile_tag_t;

    // Lane sums of one tile, lane 0 in the low word
    typedef struct packed {
        logic [`MVM_TILE-1:0][`MVM_ACC_W-1:0] sum;
        tile_tag_t                            tag;
    } partial_t;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_FETCH,
        LD_WAIT_BANK
    } loader_state_e;

    typedef enum logic {
        MAC_IDLE,
        MAC_RUN
    } mac_state_e;

endpackage

`default_nettype wire

// ==== mvm_tb.sv ====
`default_nettype none
`include "mvm_defines.svh"

module mvm_tb
    import mvm_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 20;
    localparam int TESTS       = 5;
    localparam int TEST_CYCLES = 2000;
    localparam int RUN_LIMIT   = 1000;
    localparam int POST_CYCLES = 40;
    localparam int WEIGHTS     = `MVM_ROWS * `MVM_COLS;

    logic                         clk;
    logic                         rst_n;
    load_t                        load;
    logic                         load_valid;
    logic                         start;
    logic                         busy;
    logic                         done;
    logic [$clog2(`MVM_ROWS)-1:0] res_addr;
    logic [`MVM_ACC_W-1:0]        res_data;

    // Reference copies of what the DUT should hold
    logic signed [`MVM_DATA_W-1:0] w_ref [WEIGHTS];
    logic signed [`MVM_DATA_W-1:0] v_ref [`MVM_COLS];
    logic [15:0]                   lfsr;
    load_t                         stray;
    int                            errors;
    int                            checks;

    mvm_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .load_valid (load_valid),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .res_addr   (res_addr),
        .res_data   (res_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] random_word();
        logic [15:0] w;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            w    = {w[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return w;
    endfunction

    // Dot product of one matrix row with the vector, wrapped to the result width
    function automatic logic [`MVM_ACC_W-1:0] expected_result(input int r);
        logic signed [`MVM_ACC_W-1:0] sum;
        sum = '0;
        for (int c = 0; c < `MVM_COLS; c++) begin
            sum = sum + w_ref[r * `MVM_COLS + c] * v_ref[c];
        end
        return sum;
    endfunction

    task automatic check_value(input logic [`MVM_ACC_W-1:0] got,
                               input logic [`MVM_ACC_W-1:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0d ns: %s, got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic write_word(input load_sel_e sel, input int addr, input logic [15:0] data);
        @(negedge clk);
        load.sel   = sel;
        load.addr  = `MVM_ADDR_W'(addr);
        load.data  = data;
        load_valid = 1'b1;
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    task automatic load_matrix();
        for (int i = 0; i < WEIGHTS; i++) begin
            write_word(LOAD_WEIGHT, i, w_ref[i]);
        end
    endtask

    task automatic load_vector();
        for (int i = 0; i < `MVM_COLS; i++) begin
            write_word(LOAD_VECTOR, i, v_ref[i]);
        end
    endtask

    // Start pulse, then busy and done are watched on every falling edge
    task automatic run_and_wait(input bit disturb);
        int  cycles;
        int  done_count;
        bit  finished;
        cycles     = 0;
        done_count = 0;
        finished   = 1'b0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!finished && cycles < RUN_LIMIT) begin
            check_value(busy, 1'b1, "busy during run");
            if (done) begin
                done_count++;
                finished = 1'b1;
            end
            // Second start and a host write land in the middle of the run
            if (disturb && cycles == 5) begin
                start      = 1'b1;
                load       = stray;
                load_valid = 1'b1;
            end else begin
                start      = 1'b0;
                load_valid = 1'b0;
            end
            @(negedge clk);
            cycles++;
        end
        if (!finished) begin
            errors++;
            $display("Run did not raise done within %0d cycles at %0d ns", RUN_LIMIT, $time);
        end
        for (int i = 0; i < POST_CYCLES; i++) begin
            if (done) begin
                done_count++;
            end
            check_value(busy, 1'b0, "busy after done");
            @(negedge clk);
        end
        check_value(done_count, 1, "done pulses per start");
    endtask

    task automatic read_result(input int addr, output logic [`MVM_ACC_W-1:0] data);
        @(negedge clk);
        res_addr = 3'(addr);
        @(negedge clk);
        data = res_data;
    endtask

    task automatic check_results();
        logic [`MVM_ACC_W-1:0] got;
        for (int r = 0; r < `MVM_ROWS; r++) begin
            read_result(r, got);
            check_value(got, expected_result(r), $sformatf("result %0d", r));
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_mark);
        if (errors == err_mark) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name, errors - err_mark);
        end
    endtask

    task automatic identity_matrix();
        int err_mark;
        err_mark = errors;
        @(negedge clk);
        check_value(busy, 1'b0, "busy after reset");
        check_value(done, 1'b0, "done after reset");
        for (int i = 0; i < WEIGHTS; i++) begin
            w_ref[i] = (i / `MVM_COLS == i % `MVM_COLS) ? 16'sd1 : 16'sd0;
        end
        for (int i = 0; i < `MVM_COLS; i++) begin
            v_ref[i] = random_word();
        end
        load_matrix();
        load_vector();
        run_and_wait(1'b0);
        check_results();
        report_test(1, "identity", err_mark);
    endtask

    task automatic random_matrix();
        int err_mark;
        err_mark = errors;
        for (int i = 0; i < WEIGHTS; i++) begin
            w_ref[i] = random_word();
        end
        for (int i = 0; i < `MVM_COLS; i++) begin
            v_ref[i] = random_word();
        end
        load_matrix();
        load_vector();
        run_and_wait(1'b0);
        check_results();
        report_test(2, "random", err_mark);
    endtask

    // Same data again, sums must restart on the first column tile
    task automatic rerun_same_data();
        int err_mark;
        err_mark = errors;
        run_and_wait(1'b0);
        check_results();
        report_test(3, "rerun", err_mark);
    endtask

    task automatic reload_vector();
        int err_mark;
        err_mark = errors;
        for (int i = 0; i < `MVM_COLS; i++) begin
            v_ref[i] = random_word();
        end
        load_vector();
        run_and_wait(1'b0);
        check_results();
        report_test(4, "new vector", err_mark);
    endtask

    task automatic busy_protocol();
        int err_mark;
        int col;
        err_mark = errors;
        col      = 0;
        // Aim the stray write at a row 0 weight whose vector word is nonzero
        for (int c = `MVM_COLS - 1; c >= 0; c--) begin
            if (v_ref[c] != 0) begin
                col = c;
            end
        end
        stray.sel  = LOAD_WEIGHT;
        stray.addr = `MVM_ADDR_W'(col);
        stray.data = w_ref[col] ^ 16'h5a5a;
        run_and_wait(1'b1);
        check_results();
        run_and_wait(1'b0);
        check_results();
        report_test(5, "busy protocol", err_mark);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        load       = '0;
        load_valid = 1'b0;
        start      = 1'b0;
        res_addr   = '0;
        stray      = '0;
        lfsr       = 16'd11668;
        errors     = 0;
        checks     = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        identity_matrix();
        random_matrix();
        rerun_same_data();
        reload_vector();
        busy_protocol();

        $display("tests: %0d, checks: %0d, errors: %0d", TESTS, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog sized from the test count and a per-test cycle budget
    initial begin
        #(TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("Timeout: tests still running after %0d cycles", TESTS * TEST_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mvm_top.sv ====
`default_nettype none
`include "mvm_defines.svh"

module mvm_top
    import mvm_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  load_t                        load,
    input  logic                         load_valid,
    input  logic                         start,
    output logic                         busy,
    output logic                         done,
    input  logic [$clog2(`MVM_ROWS)-1:0] res_addr,
    output logic [`MVM_ACC_W-1:0]        res_data
);

    load_sel_e                                            rd_sel;
    logic [`MVM_ADDR_W-1:0]                               rd_addr;
    logic [`MVM_DATA_W-1:0]                               rd_data;
    logic [1:0]                                           bank_full;
    logic                                                 wr_bank;
    logic [$clog2(`MVM_TILE*`MVM_TILE)-1:0]               wr_index;
    logic [`MVM_DATA_W-1:0]                               wr_weight;
    logic [$clog2(`MVM_TILE)-1:0]                         wr_vec_index;
    logic [`MVM_DATA_W-1:0]                               wr_vec;
    tile_tag_t                                            wr_tag;
    logic [1:0]                                           wr_en;
    logic                                                 commit;
    logic                                                 rd_bank;
    logic                                                 bank_release;
    logic [`MVM_TILE-1:0][`MVM_TILE-1:0][`MVM_DATA_W-1:0] weights;
    logic [`MVM_TILE-1:0][`MVM_DATA_W-1:0]                vec;
    tile_tag_t                                            tag;
    partial_t                                             part;
    logic                                                 part_valid;
    logic                                                 result_written;

    global_mem u_global_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .load_valid (load_valid),
        .busy       (busy),
        .rd_sel     (rd_sel),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    tile_loader u_tile_loader (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .busy           (busy),
        .rd_sel         (rd_sel),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .bank_full      (bank_full),
        .wr_bank        (wr_bank),
        .wr_index       (wr_index),
        .wr_weight      (wr_weight),
        .wr_vec_index   (wr_vec_index),
        .wr_vec         (wr_vec),
        .wr_tag         (wr_tag),
        .wr_en          (wr_en),
        .commit         (commit),
        .done           (done),
        .result_written (result_written)
    );

    tile_buffer u_tile_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_bank      (wr_bank),
        .wr_index     (wr_index),
        .wr_weight    (wr_weight),
        .wr_vec_index (wr_vec_index),
        .wr_vec       (wr_vec),
        .wr_tag       (wr_tag),
        .wr_en        (wr_en),
        .commit       (commit),
        .rd_bank      (rd_bank),
        .bank_release (bank_release),
        .weights      (weights),
        .vec          (vec),
        .tag          (tag),
        .bank_full    (bank_full)
    );

    mac_array u_mac_array (
        .clk          (clk),
        .rst_n        (rst_n),
        .bank_full    (bank_full),
        .rd_bank      (rd_bank),
        .weights      (weights),
        .vec          (vec),
        .tag          (tag),
        .bank_release (bank_release),
        .part         (part),
        .part_valid   (part_valid)
    );

    row_accumulator u_row_accumulator (
        .clk            (clk),
        .rst_n          (rst_n),
        .part           (part),
        .part_valid     (part_valid),
        .res_addr       (res_addr),
        .res_data       (res_data),
        .result_written (result_written)
    );

endmodule

`default_nettype wire

// ==== row_accumulator.sv ====
`default_nettype none
`include "mvm_defines.svh"

module row_accumulator
    import mvm_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  partial_t                     part,
    input  logic                         part_valid,
    input  logic [$clog2(`MVM_ROWS)-1:0] res_addr,
    output logic [`MVM_ACC_W-1:0]        res_data,
    output logic                         result_written
);

    localparam int RT_W    = $clog2(`MVM_ROWS / `MVM_TILE);
    localparam int RT_LAST = `MVM_ROWS / `MVM_TILE - 1;

    logic [`MVM_ACC_W-1:0] run_sum  [`MVM_TILE];
    logic [`MVM_ACC_W-1:0] next_sum [`MVM_TILE];
    logic [`MVM_ACC_W-1:0] res_mem  [`MVM_ROWS];

    // First column tile of a row tile restarts the sums
    always_comb begin
        for (int l = 0; l < `MVM_TILE; l++) begin
            if (part.tag.first_col) begin
                next_sum[l] = part.sum[l];
            end else begin
                next_sum[l] = run_sum[l] + part.sum[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (part_valid) begin
            for (int l = 0; l < `MVM_TILE; l++) begin
                run_sum[l] <= next_sum[l];
                if (part.tag.last_col) begin
                    res_mem[part.tag.row_tile * `MVM_TILE + l] <= next_sum[l];
                end
            end
        end
        res_data <= res_mem[res_addr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_written <= 1'b0;
        end else begin
            result_written <= part_valid && part.tag.last_col
                              && (part.tag.row_tile == RT_W'(RT_LAST));
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module mvm_tb -o mvm_sim \
    || { echo "Build failed"; exit 1; }
./obj_dir/mvm_sim | tee /dev/stderr | grep -x '\*\* PASS \*\*' > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== tile_buffer.sv ====
`default_nettype none
`include "mvm_defines.svh"

module tile_buffer
    import mvm_pkg::*;
(
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             wr_bank,
    input  logic [$clog2(`MVM_TILE*`MVM_TILE)-1:0]           wr_index,
    input  logic [`MVM_DATA_W-1:0]                           wr_weight,
    input  logic [$clog2(`MVM_TILE)-1:0]                     wr_vec_index,
    input  logic [`MVM_DATA_W-1:0]                           wr_vec,
    input  tile_tag_t                                        wr_tag,
    input  logic [1:0]                                       wr_en,
    input  logic                                             commit,
    input  logic                                             rd_bank,
    input  logic                                             bank_release,
    output logic [`MVM_TILE-1:0][`MVM_TILE-1:0][`MVM_DATA_W-1:0] weights,
    output logic [`MVM_TILE-1:0][`MVM_DATA_W-1:0]            vec,
    output tile_tag_t                                        tag,
    output logic [1:0]                                       bank_full
);

    localparam int LANE_W = $clog2(`MVM_TILE);

    logic [`MVM_TILE-1:0][`MVM_TILE-1:0][`MVM_DATA_W-1:0] w_bank [2];
    logic [`MVM_TILE-1:0][`MVM_DATA_W-1:0]                v_bank [2];
    tile_tag_t                                            tag_bank [2];

    // Weight index splits into tile row (high bits) and tile column
    always_ff @(posedge clk) begin
        if (wr_en[0]) begin
            w_bank[wr_bank][wr_index[2*LANE_W-1:LANE_W]][wr_index[LANE_W-1:0]] <= wr_weight;
        end
        if (wr_en[1]) begin
            v_bank[wr_bank][wr_vec_index] <= wr_vec;
        end
        if (commit) begin
            tag_bank[wr_bank] <= wr_tag;
        end
    end

    // Loader sets a flag, the MAC array clears it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_full <= '0;
        end else begin
            if (bank_release) begin
                bank_full[rd_bank] <= 1'b0;
            end
            if (commit) begin
                bank_full[wr_bank] <= 1'b1;
            end
        end
    end

    assign weights = w_bank[rd_bank];
    assign vec     = v_bank[rd_bank];
    assign tag     = tag_bank[rd_bank];

endmodule

`default_nettype wire

// ==== tile_loader.sv ====
`default_nettype none
`include "mvm_defines.svh"

module tile_loader
    import mvm_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start,
    output logic                                   busy,
    output load_sel_e                              rd_sel,
    output logic [`MVM_ADDR_W-1:0]                 rd_addr,
    input  logic [`MVM_DATA_W-1:0]                 rd_data,
    input  logic [1:0]                             bank_full,
    output logic                                   wr_bank,
    output logic [$clog2(`MVM_TILE*`MVM_TILE)-1:0] wr_index,
    output logic [`MVM_DATA_W-1:0]                 wr_weight,
    output logic [$clog2(`MVM_TILE)-1:0]           wr_vec_index,
    output logic [`MVM_DATA_W-1:0]                 wr_vec,
    output tile_tag_t                              wr_tag,
    output logic [1:0]                             wr_en,
    output logic                                   commit,
    output logic                                   done,
    input  logic                                   result_written
);

    localparam int TILE_WORDS = `MVM_TILE * `MVM_TILE;
    localparam int LAST_CNT   = TILE_WORDS + `MVM_TILE - 1;
    localparam int CNT_W      = $clog2(LAST_CNT + 1);
    localparam int IDX_W      = $clog2(TILE_WORDS);
    localparam int LANE_W     = $clog2(`MVM_TILE);
    localparam int RT_W       = $clog2(`MVM_ROWS / `MVM_TILE);
    localparam int CT_W       = $clog2(`MVM_COLS / `MVM_TILE);
    localparam int RT_LAST    = `MVM_ROWS / `MVM_TILE - 1;
    localparam int CT_LAST    = `MVM_COLS / `MVM_TILE - 1;

    loader_state_e    state;
    logic [RT_W-1:0]  rt;
    logic [CT_W-1:0]  ct;
    logic [CNT_W-1:0] cnt;
    logic             bank;
    logic             issue;
    logic             is_vec;
    logic             tile_end;
    logic             last_tile;
    tile_tag_t        cur_tag;
    logic             d_valid;
    logic             d_last;
    logic [CNT_W-1:0] d_cnt;

    // Words 0..15 are the weight tile, 16..19 the vector slice
    assign issue     = (state == LD_FETCH);
    assign is_vec    = (cnt >= CNT_W'(TILE_WORDS));
    assign tile_end  = (cnt == CNT_W'(LAST_CNT));
    assign last_tile = (rt == RT_W'(RT_LAST)) && (ct == CT_W'(CT_LAST));

    assign cur_tag.row_tile  = rt;
    assign cur_tag.first_col = (ct == '0);
    assign cur_tag.last_col  = (ct == CT_W'(CT_LAST));

    always_comb begin
        if (is_vec) begin
            rd_sel  = LOAD_VECTOR;
            rd_addr = `MVM_ADDR_W'(ct * `MVM_TILE + cnt[LANE_W-1:0]);
        end else begin
            rd_sel  = LOAD_WEIGHT;
            rd_addr = `MVM_ADDR_W'((rt * `MVM_TILE + cnt[IDX_W-1:LANE_W]) * `MVM_COLS
                                   + ct * `MVM_TILE + cnt[LANE_W-1:0]);
        end
    end

    // Row tiles outer, column tiles inner, banks alternate per tile
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LD_IDLE;
            rt    <= '0;
            ct    <= '0;
            cnt   <= '0;
            bank  <= 1'b0;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (start && !busy) begin
                        rt    <= '0;
                        ct    <= '0;
                        cnt   <= '0;
                        state <= LD_WAIT_BANK;
                    end
                end
                LD_WAIT_BANK: begin
                    if (!bank_full[bank]) begin
                        state <= LD_FETCH;
                    end
                end
                LD_FETCH: begin
                    cnt <= cnt + 1'b1;
                    if (tile_end) begin
                        cnt  <= '0;
                        bank <= ~bank;
                        if (ct == CT_W'(CT_LAST)) begin
                            ct <= '0;
                            rt <= rt + 1'b1;
                        end else begin
                            ct <= ct + 1'b1;
                        end
                        state <= last_tile ? LD_IDLE : LD_WAIT_BANK;
                    end
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

    // Run ends once the accumulator has stored the last row tile
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= busy && result_written;
            if (start && !busy) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
            commit  <= 1'b0;
        end else begin
            d_valid <= issue;
            commit  <= d_valid && d_last;
        end
    end

    // Word position, bank and tag follow each read through the memory latency
    always_ff @(posedge clk) begin
        if (issue) begin
            d_cnt   <= cnt;
            d_last  <= tile_end;
            wr_bank <= bank;
            wr_tag  <= cur_tag;
        end
    end

    assign wr_index     = d_cnt[IDX_W-1:0];
    assign wr_vec_index = d_cnt[LANE_W-1:0];
    assign wr_weight    = rd_data;
    assign wr_vec       = rd_data;
    // Bit 0 writes a weight, bit 1 a vector word
    assign wr_en[0]     = d_valid && (d_cnt < CNT_W'(TILE_WORDS));
    assign wr_en[1]     = d_valid && (d_cnt >= CNT_W'(TILE_WORDS));

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
mvm_pkg.sv
global_mem.sv
tile_loader.sv
tile_buffer.sv
mac_array.sv
row_accumulator.sv
mvm_top.sv
mvm_chk.sv
mvm_tb.sv
